// ==== bench/memChecker.sv ====
`default_nettype none

module memChecker import busPkg::*, lsuPkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       resultValid,
    input lsuResult_t result,
    input logic       fetchDone,
    input dataWord_u  fetchWord
);

    lsuResult_t  expResults [$];
    logic [31:0] expFetches [$];
    string       testName = "none";
    int          testCount = 0;
    int          checkCount = 0;
    int          errorCount = 0;
    int          testErrors = 0;

    task automatic startTest(input string name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic expectResult(input lsuResult_t r);
        expResults.push_back(r);
    endtask

    task automatic expectFetch(input logic [31:0] word);
        expFetches.push_back(word);
    endtask

    function automatic int pending();
        return expResults.size() + expFetches.size();
    endfunction

    task automatic noteError();
        errorCount++;
        testErrors++;
    endtask

    task automatic checkFlag(input string what, input logic expected, input logic actual);
        checkCount++;
        if (actual !== expected) begin
            $display("Error %s: %s expected %0b, actual %0b", testName, what, expected, actual);
            noteError();
        end
    endtask

    task automatic finishTest();
        testCount++;
        $display("test %s done with %0d errors", testName, testErrors);
    endtask

    task automatic printSummary();
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    endtask

    // outputs change just after the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        lsuResult_t exp;
        if (!rst && resultValid) begin
            if (expResults.size() == 0) begin
                $display("%s: a result with nick %0d came back but none was pending",
                         testName, result.nick);
                noteError();
            end else begin
                exp = expResults.pop_front();
                checkCount++;
                if (result !== exp) begin
                    $display("Error %s: expected nick %0d store %0b value %h, %s %0d %0b %h",
                             testName, exp.nick, exp.isStore, exp.value,
                             "actual nick/store/value", result.nick, result.isStore,
                             result.value);
                    noteError();
                end
            end
        end
        if (!rst && fetchDone) begin
            if (expFetches.size() == 0) begin
                $display("%s: a fetch completed that was never requested", testName);
                noteError();
            end else begin
                checkCount++;
                if (fetchWord.word !== expFetches[0]) begin
                    $display("Error %s: fetch expected %h, actual %h",
                             testName, expFetches[0], fetchWord.word);
                    noteError();
                end
                void'(expFetches.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/memSubsystemTb.sv ====
`default_nettype none

`include "dmem_settings.svh"

module memSubsystemTb import busPkg::*, lsuPkg::*; ();

    localparam int waitLimit   = 2000;
    localparam int regionBase  = 'h100;   // 64 bytes of data traffic for the burst tests
    localparam int fetchRegion = 'h400;

    logic                   clk;
    logic                   rst;
    logic                   opValid;
    lsuOp_t                 op;
    logic                   full;
    logic                   overflow;
    logic                   fetchEn;
    logic [`ADDR_WIDTH-1:0] fetchAddr;
    logic                   fetchBusy;
    logic                   fetchDone;
    dataWord_u              fetchWord;
    logic                   resultValid;
    lsuResult_t             result;

    logic [7:0]             model [`RAM_BYTES];
    logic [31:0]            rngState;
    logic [`NICK_WIDTH-1:0] nextNick;

    memSubsystem i_dut (
        .clk         (clk),
        .rst         (rst),
        .opValid     (opValid),
        .op          (op),
        .full        (full),
        .overflow    (overflow),
        .fetchEn     (fetchEn),
        .fetchAddr   (fetchAddr),
        .fetchBusy   (fetchBusy),
        .fetchDone   (fetchDone),
        .fetchWord   (fetchWord),
        .resultValid (resultValid),
        .result      (result)
    );

    memChecker i_check (
        .clk         (clk),
        .rst         (rst),
        .resultValid (resultValid),
        .result      (result),
        .fetchDone   (fetchDone),
        .fetchWord   (fetchWord)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic int lenBytes(input memLen_t len);
        case (len)
            lenByte: return 1;
            lenHalf: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic memLen_t randLen(input logic [31:0] r);
        case (r % 32'd3)
            32'd0:   return lenByte;
            32'd1:   return lenHalf;
            default: return lenWord;
        endcase
    endfunction

    function automatic lsuKind_t randLoad(input logic [31:0] r);
        return r[0] ? loadSigned : loadUnsigned;
    endfunction

    function automatic logic [`ADDR_WIDTH-1:0] alignAddr(input logic [`ADDR_WIDTH-1:0] a,
                                                         input memLen_t len);
        case (len)
            lenWord: return {a[`ADDR_WIDTH-1:2], 2'b00};
            lenHalf: return {a[`ADDR_WIDTH-1:1], 1'b0};
            default: return a;
        endcase
    endfunction

    function automatic logic [31:0] readModel(input logic [`ADDR_WIDTH-1:0] addr, input int n);
        logic [31:0] word;
        int          i;
        word = '0;
        for (i = 0; i < n; i++) begin
            word[8*i +: 8] = model[addr + `ADDR_WIDTH'(i)];   // little-endian
        end
        return word;
    endfunction

    function automatic void writeModel(input lsuOp_t o);
        int i;
        for (i = 0; i < lenBytes(o.len); i++) begin
            model[o.addr + `ADDR_WIDTH'(i)] = o.storeData[8*i +: 8];
        end
    endfunction

    // expected result of one operation against the model as it stands before the operation
    function automatic lsuResult_t refResult(input lsuOp_t o);
        lsuResult_t r;
        int         n;
        int         i;
        n         = lenBytes(o.len);
        r.nick    = o.nick;
        r.isStore = (o.kind == store);
        r.value   = '0;
        if (o.kind != store) begin
            r.value = readModel(o.addr, n);
            if (o.kind == loadSigned && r.value[8*n-1]) begin
                for (i = n; i < 4; i++) begin
                    r.value[8*i +: 8] = 8'hff;
                end
            end
        end
        return r;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped early");
    endtask

    task automatic sendOp(input lsuKind_t kind, input memLen_t len,
                          input logic [`ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        lsuOp_t o;
        int     n;
        n = 0;
        while (full && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        if (full) begin
            abortRun("timeout: the queue stayed full");
        end
        o.kind      = kind;
        o.len       = len;
        o.addr      = alignAddr(addr, len);
        o.storeData = data;
        o.nick      = nextNick;
        nextNick    = nextNick + 1'b1;
        i_check.expectResult(refResult(o));
        if (kind == store) begin
            writeModel(o);
        end
        opValid = 1'b1;
        op      = o;
        @(negedge clk);
        opValid = 1'b0;
    endtask

    // strobe while the queue is full, so the model must not see it
    task automatic dropOp();
        op           = '0;
        op.kind      = store;
        op.len       = lenWord;
        op.addr      = `ADDR_WIDTH'(regionBase);
        op.storeData = 32'hdead_beef;
        op.nick      = nextNick;
        opValid      = 1'b1;
        @(negedge clk);
        opValid = 1'b0;
    endtask

    task automatic sendFetch(input logic [`ADDR_WIDTH-1:0] addr);
        int n;
        n = 0;
        while (fetchBusy && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        if (fetchBusy) begin
            abortRun("timeout: the fetch port stayed busy");
        end
        i_check.expectFetch(readModel(addr, 4));
        fetchEn   = 1'b1;
        fetchAddr = addr;
        @(negedge clk);
        fetchEn = 1'b0;
        i_check.checkFlag("fetchBusy", 1'b1, fetchBusy);   // pending from the strobe edge on
    endtask

    task automatic waitDrain();
        int n;
        n = 0;
        while (i_check.pending() != 0 && n < waitLimit) begin
            @(negedge clk);
            n++;
        end
        if (i_check.pending() != 0) begin
            abortRun("timeout: some results never came back");
        end
    endtask

    task automatic storeThenLoad(input memLen_t len);
        logic [31:0] r;
        r = nextRand();
        sendOp(store, len, r[`ADDR_WIDTH-1:0], nextRand());
        sendOp(randLoad(r >> 7), len, r[`ADDR_WIDTH-1:0], '0);
    endtask

    task automatic extendCase(input memLen_t len);
        logic [31:0] r;
        r = nextRand();
        sendOp(store, len, r[`ADDR_WIDTH-1:0], nextRand() | 32'h8080_8080);
        sendOp(loadSigned, len, r[`ADDR_WIDTH-1:0], '0);
        sendOp(loadUnsigned, len, r[`ADDR_WIDTH-1:0], '0);
    endtask

    task automatic regionOp();
        logic [31:0]            r;
        logic [`ADDR_WIDTH-1:0] a;
        r      = nextRand();
        a      = `ADDR_WIDTH'(regionBase);
        a[5:0] = r[5:0];
        if (r[9:8] == 2'b00) begin
            sendOp(store, randLen(r >> 12), a, nextRand());
        end else begin
            sendOp(randLoad(r >> 10), randLen(r >> 12), a, '0);
        end
    endtask

    initial begin
        int                     i;
        logic [31:0]            r;
        logic [`ADDR_WIDTH-1:0] a;
        clk       = 1'b0;
        rst       = 1'b1;
        opValid   = 1'b0;
        op        = '0;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        rngState  = 32'h1f98;
        nextNick  = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        i_check.startTest("reset");
        i_check.checkFlag("full", 1'b0, full);
        i_check.checkFlag("overflow", 1'b0, overflow);
        i_check.checkFlag("resultValid", 1'b0, resultValid);
        i_check.checkFlag("fetchDone", 1'b0, fetchDone);
        i_check.checkFlag("fetchBusy", 1'b0, fetchBusy);
        i_check.finishTest();

        i_check.startTest("storeLoad");
        for (i = 0; i < 6; i++) begin
            storeThenLoad(lenWord);
            storeThenLoad(lenHalf);
            storeThenLoad(lenByte);
        end
        waitDrain();
        i_check.finishTest();

        i_check.startTest("extension");
        for (i = 0; i < 4; i++) begin
            extendCase(lenByte);
            extendCase(lenHalf);
        end
        waitDrain();
        i_check.finishTest();

        i_check.startTest("backlog");
        for (i = 0; i < 16; i++) begin
            sendOp(store, lenWord, `ADDR_WIDTH'(regionBase + 4 * i), nextRand());
        end
        for (i = 0; i < 24; i++) begin
            regionOp();
        end
        waitDrain();
        i_check.checkFlag("overflow", 1'b0, overflow);
        i_check.finishTest();

        i_check.startTest("overflow");
        i = 0;
        while (!full && i < 20) begin
            regionOp();
            i++;
        end
        if (!full) begin
            abortRun("the queue never filled up");
        end
        dropOp();
        for (i = 0; i < 8; i++) begin
            regionOp();
        end
        waitDrain();
        i_check.checkFlag("overflow", 1'b1, overflow);
        i_check.finishTest();

        i_check.startTest("fetch");
        for (i = 0; i < 8; i++) begin
            sendOp(store, lenWord, `ADDR_WIDTH'(fetchRegion + 4 * i), nextRand());
        end
        waitDrain();
        for (i = 0; i < 24; i++) begin
            if (i % 4 == 1) begin
                r      = nextRand();
                a      = `ADDR_WIDTH'(fetchRegion);
                a[4:2] = r[2:0];
                sendFetch(a);
            end
            regionOp();
        end
        waitDrain();
        i_check.finishTest();

        i_check.printSummary();
        if (i_check.errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/busPkg.sv ====
`default_nettype none

`include "dmem_settings.svh"

package busPkg;

    // encoded so that the value is also the index of the top byte lane
    typedef enum logic [1:0] {
        lenByte = 2'd0,
        lenHalf = 2'd1,
        lenWord = 2'd3
    } memLen_t;

    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lanes;     // lane 0 is the lowest address, little-endian
    } dataWord_u;

    typedef struct packed {
        logic                   isStore;
        logic [`ADDR_WIDTH-1:0] addr;
        memLen_t                len;
        dataWord_u              data;
    } memReq_t;

    typedef struct packed {
        logic dataBlocked;          // bit 1
        logic fetchBusy;            // bit 0
    } memWait_t;

endpackage

`default_nettype wire

// ==== hw/byteRam.sv ====
`default_nettype none

`include "dmem_settings.svh"

module byteRam (
    input  logic                   clk,
    input  logic [`ADDR_WIDTH-1:0] addr,
    input  logic                   we,
    input  logic [7:0]             wdata,
    output logic [7:0]             rdata
);

    logic [7:0] mem [`RAM_BYTES];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
            rdata     <= wdata;     // write-first, a read of the written byte sees new data
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/dataCache.sv ====
`default_nettype none

module dataCache import busPkg::*, lsuPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      issueValid,
    input  lsuOp_t    issueOp,
    output logic      cacheReady,
    input  memWait_t  memWait,
    output logic      dataEn,
    output memReq_t   dataReq,
    input  logic      dataDone,
    input  dataWord_u dataRdata,
    output logic      doneValid,
    output lsuDone_t  done
);

    logic   occupied;
    lsuOp_t entry;

    assign cacheReady = !occupied;
    assign dataEn     = occupied && !memWait.dataBlocked;

    always_comb begin
        dataReq.isStore   = (entry.kind == store);
        dataReq.addr      = entry.addr;
        dataReq.len       = entry.len;
        dataReq.data.word = entry.storeData;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied  <= 1'b0;
            doneValid <= 1'b0;
        end else begin
            doneValid <= dataDone;
            if (dataDone) begin
                occupied <= 1'b0;
            end
            if (issueValid) begin
                occupied <= 1'b1;     // only offered while empty, so never clashes with done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            entry <= issueOp;
        end
        if (dataDone) begin
            done.kind <= entry.kind;
            done.len  <= entry.len;
            done.nick <= entry.nick;
            done.data <= dataRdata;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dmem_settings.svh ====
`ifndef DMEM_SETTINGS_SVH
`define DMEM_SETTINGS_SVH

// byte address into the data RAM
`define ADDR_WIDTH 17

// tag that follows each load/store back to the core
`define NICK_WIDTH 4

// entries in the load/store queue, not counting the one in the cache holder
`define LSQ_DEPTH 4

`define RAM_BYTES (1 << `ADDR_WIDTH)

`endif

// ==== hw/loadResponse.sv ====
`default_nettype none

module loadResponse import busPkg::*, lsuPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       doneValid,
    input  lsuDone_t   done,
    output logic       resultValid,
    output lsuResult_t result
);

    logic       signBit;
    logic [31:0] loadValue;

    // the length code doubles as the index of the most significant lane
    assign signBit = (done.kind == loadSigned) && done.data.lanes[done.len][7];

    always_comb begin
        case (done.len)
            lenByte: loadValue = {{24{signBit}}, done.data.lanes[0]};
            lenHalf: loadValue = {{16{signBit}}, done.data.lanes[1:0]};
            default: loadValue = done.data.word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= doneValid;
        end
    end

    always_ff @(posedge clk) begin
        if (doneValid) begin
            result.nick    <= done.nick;
            result.isStore <= (done.kind == store);
            result.value   <= (done.kind == store) ? 32'd0 : loadValue;
        end
    end

endmodule

`default_nettype wire

// ==== hw/loadStoreQueue.sv ====
`default_nettype none

`include "dmem_settings.svh"

module loadStoreQueue import lsuPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   opValid,
    input  lsuOp_t op,
    input  logic   cacheReady,
    output logic   issueValid,
    output lsuOp_t issueOp,
    output logic   full,
    output logic   overflow
);

    localparam int ptrWidth   = $clog2(`LSQ_DEPTH);
    localparam int countWidth = $clog2(`LSQ_DEPTH + 1);

    lsuOp_t                entries [`LSQ_DEPTH];
    logic [ptrWidth-1:0]   wrPtr;
    logic [ptrWidth-1:0]   rdPtr;
    logic [countWidth-1:0] count;
    logic                  push;
    logic                  pop;

    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        if (ptr == ptrWidth'(`LSQ_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full       = (count == countWidth'(`LSQ_DEPTH));
    assign push       = opValid && !full;     // a strobe into a full queue is lost
    assign issueValid = (count != '0) && cacheReady;
    assign pop        = issueValid;
    assign issueOp    = entries[rdPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (opValid && full) begin
                overflow <= 1'b1;     // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= op;
        end
    end

endmodule

`default_nettype wire

// ==== hw/lsuPkg.sv ====
`default_nettype none

`include "dmem_settings.svh"

package lsuPkg;

    import busPkg::*;

    typedef enum logic [1:0] {
        loadSigned   = 2'd0,
        loadUnsigned = 2'd1,
        store        = 2'd2
    } lsuKind_t;

    typedef struct packed {
        lsuKind_t               kind;
        memLen_t                len;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [31:0]            storeData;
        logic [`NICK_WIDTH-1:0] nick;
    } lsuOp_t;

    // raw completion as it leaves the cache holder
    typedef struct packed {
        lsuKind_t               kind;
        memLen_t                len;
        logic [`NICK_WIDTH-1:0] nick;
        dataWord_u              data;
    } lsuDone_t;

    typedef struct packed {
        logic [`NICK_WIDTH-1:0] nick;
        logic                   isStore;
        logic [31:0]            value;
    } lsuResult_t;

endpackage

`default_nettype wire

// ==== hw/memController.sv ====
`default_nettype none

`include "dmem_settings.svh"

module memController import busPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetchEn,
    input  logic [`ADDR_WIDTH-1:0] fetchAddr,
    output logic                   fetchDone,
    output dataWord_u              fetchWord,
    input  logic                   dataEn,
    input  memReq_t                dataReq,
    output logic                   dataDone,
    output dataWord_u              dataRdata,
    output memWait_t               memWait,
    output logic [`ADDR_WIDTH-1:0] ramAddr,
    output logic                   ramWe,
    output logic [7:0]             ramWdata,
    input  logic [7:0]             ramRdata
);

    typedef enum logic [1:0] {
        stIdle,
        stFetch,
        stData
    } ctrlState_t;

    ctrlState_t             state;
    logic                   fetchPending;
    logic [`ADDR_WIDTH-1:0] fetchBase;
    memReq_t                req;
    logic [2:0]             cnt;        // cycles spent in the current transfer
    logic [2:0]             byteCount;
    logic [1:0]             laneIdx;
    logic [`ADDR_WIDTH-1:0] offset;
    logic                   accept;
    dataWord_u              rdBuf;
    dataWord_u              assembled;

    assign byteCount = {1'b0, req.len} + 3'd1;
    assign laneIdx   = cnt[1:0] - 2'd1;   // read data lags the address by one cycle
    assign offset    = {{(`ADDR_WIDTH - 3){1'b0}}, cnt};
    assign accept    = (state == stIdle) && !fetchPending && dataEn;

    always_comb begin
        assembled = rdBuf;
        if (state != stIdle && cnt != 3'd0) begin
            assembled.lanes[laneIdx] = ramRdata;
        end
    end

    assign fetchWord = assembled;
    assign dataRdata = assembled;
    assign fetchDone = (state == stFetch) && (cnt == 3'd4);
    assign dataDone  = (state == stData) &&
                       (req.isStore ? (cnt == byteCount - 3'd1) : (cnt == byteCount));

    assign memWait.fetchBusy   = fetchPending || (state == stFetch);
    assign memWait.dataBlocked = fetchPending || (state != stIdle);

    always_comb begin
        ramAddr  = '0;
        ramWe    = 1'b0;
        ramWdata = '0;
        if (state == stFetch && cnt != 3'd4) begin
            ramAddr = fetchBase + offset;
        end else if (state == stData && cnt < byteCount) begin
            ramAddr  = req.addr + offset;
            ramWe    = req.isStore;
            ramWdata = req.data.lanes[cnt[1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= stIdle;
            fetchPending <= 1'b0;
            cnt          <= '0;
        end else begin
            case (state)
                stIdle: begin
                    cnt <= '0;
                    if (fetchPending) begin
                        state        <= stFetch;
                        fetchPending <= 1'b0;
                    end else if (dataEn) begin
                        state <= stData;
                    end
                end
                stFetch: begin
                    if (fetchDone) begin
                        state <= stIdle;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
                default: begin
                    if (dataDone) begin
                        state <= stIdle;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
            endcase
            if (fetchEn) begin
                fetchPending <= 1'b1;     // held until the bus is free
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchEn) begin
            fetchBase <= fetchAddr;
        end
        if (accept) begin
            req <= dataReq;
        end
        if (state != stIdle) begin
            rdBuf <= assembled;
        end
    end

endmodule

`default_nettype wire

// ==== hw/memSubsystem.sv ====
`default_nettype none

`include "dmem_settings.svh"

module memSubsystem import busPkg::*, lsuPkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   opValid,
    input  lsuOp_t                 op,
    output logic                   full,
    output logic                   overflow,
    input  logic                   fetchEn,
    input  logic [`ADDR_WIDTH-1:0] fetchAddr,
    output logic                   fetchBusy,
    output logic                   fetchDone,
    output dataWord_u              fetchWord,
    output logic                   resultValid,
    output lsuResult_t             result
);

    logic                   issueValid;
    lsuOp_t                 issueOp;
    logic                   cacheReady;
    memWait_t               memWait;
    logic                   dataEn;
    memReq_t                dataReq;
    logic                   dataDone;
    dataWord_u              dataRdata;
    logic                   doneValid;
    lsuDone_t               done;
    logic [`ADDR_WIDTH-1:0] ramAddr;
    logic                   ramWe;
    logic [7:0]             ramWdata;
    logic [7:0]             ramRdata;

    assign fetchBusy = memWait.fetchBusy;

    loadStoreQueue i_queue (
        .clk        (clk),
        .rst        (rst),
        .opValid    (opValid),
        .op         (op),
        .cacheReady (cacheReady),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .full       (full),
        .overflow   (overflow)
    );

    dataCache i_cache (
        .clk        (clk),
        .rst        (rst),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .cacheReady (cacheReady),
        .memWait    (memWait),
        .dataEn     (dataEn),
        .dataReq    (dataReq),
        .dataDone   (dataDone),
        .dataRdata  (dataRdata),
        .doneValid  (doneValid),
        .done       (done)
    );

    memController i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchWord (fetchWord),
        .dataEn    (dataEn),
        .dataReq   (dataReq),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .memWait   (memWait),
        .ramAddr   (ramAddr),
        .ramWe     (ramWe),
        .ramWdata  (ramWdata),
        .ramRdata  (ramRdata)
    );

    byteRam i_ram (
        .clk   (clk),
        .addr  (ramAddr),
        .we    (ramWe),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

    loadResponse i_resp (
        .clk         (clk),
        .rst         (rst),
        .doneValid   (doneValid),
        .done        (done),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+hw
hw/busPkg.sv
hw/lsuPkg.sv
hw/loadStoreQueue.sv
hw/dataCache.sv
hw/memController.sv
hw/byteRam.sv
hw/loadResponse.sv
hw/memSubsystem.sv
bench/memChecker.sv
bench/memSubsystemTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f list.f --top-module memSubsystemTb -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null
[ -f sim.log ] && ! grep -q "Test failed" sim.log \
    && grep -q "Test completed successfully" sim.log || exit 1
